// ==== Bender.yml ====
package:
  name: tdc_channel

sources:
  - hw/tdc_pkg.sv
  - hw/coarse_counter.sv
  - hw/tdl_encoder.sv
  - hw/tdc_controller.sv
  - hw/word_broker.sv
  - hw/word_fifo.sv
  - hw/tdc_channel_top.sv
  - target: test
    files:
      - tb/tdc_tb.sv

// ==== hw/coarse_counter.sv ====
`timescale 1ns/1ps

module coarse_counter (
	input logic CLK,
	input logic arst_n,
	input logic trig_start,
	output tdc_pkg::coarse_t coarse,
	output tdc_pkg::stamp_t time_now
);

	logic overflow;

	assign overflow = coarse[tdc_pkg::COUNTER_BITS-1];

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			coarse <= '0;
		end else if (trig_start) begin
			coarse <= '0;
		end else if (!overflow) begin
			// stops once the MSB is reached
			coarse <= coarse + 1'b1;
		end
	end

	// free-running and only cleared by the async reset
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			time_now <= '0;
		end else begin
			time_now <= time_now + 1'b1;
		end
	end

endmodule

// ==== hw/tdc_channel_top.sv ====
`timescale 1ns/1ps

module tdc_channel_top (
	input logic CLK,
	input logic arst_n,
	input logic hit,
	input logic trig,
	input logic calib_req,
	input logic reset_req,
	input logic en_write_timestamp,
	input tdc_pkg::fine_t fine_phase,
	input tdc_pkg::tap_t taps,
	input logic out_ready,
	output logic out_valid,
	output tdc_pkg::tdc_word_t out_word
);

	logic trig_start;
	logic almost_full;
	logic word_valid;
	tdc_pkg::coarse_t coarse;
	tdc_pkg::stamp_t time_now;
	tdc_pkg::stamp_t pulse_count;
	tdc_pkg::tdl_t tdl_count;
	tdc_pkg::tdc_state_e tdc_state;
	tdc_pkg::tdc_word_t word;

	coarse_counter coarse_counter_inst (
		.CLK(CLK),
		.arst_n(arst_n),
		.trig_start(trig_start),
		.coarse(coarse),
		.time_now(time_now)
	);

	tdl_encoder tdl_encoder_inst (
		.CLK(CLK),
		.arst_n(arst_n),
		.taps(taps),
		.tdl_count(tdl_count)
	);

	tdc_controller tdc_controller_inst (
		.CLK(CLK),
		.arst_n(arst_n),
		.hit(hit),
		.trig(trig),
		.calib_req(calib_req),
		.reset_req(reset_req),
		.almost_full(almost_full),
		.tdc_state(tdc_state),
		.trig_start(trig_start),
		.pulse_count(pulse_count)
	);

	word_broker word_broker_inst (
		.CLK(CLK),
		.arst_n(arst_n),
		.tdc_state(tdc_state),
		.coarse(coarse),
		.fine_phase(fine_phase),
		.tdl_count(tdl_count),
		.pulse_count(pulse_count),
		.time_now(time_now),
		.en_write_timestamp(en_write_timestamp),
		.word_valid(word_valid),
		.word(word)
	);

	word_fifo word_fifo_inst (
		.CLK(CLK),
		.arst_n(arst_n),
		.word_valid(word_valid),
		.word(word),
		.out_ready(out_ready),
		.out_valid(out_valid),
		.out_word(out_word),
		.almost_full(almost_full)
	);

endmodule

// ==== hw/tdc_controller.sv ====
`timescale 1ns/1ps

module tdc_controller (
	input logic CLK,
	input logic arst_n,
	input logic hit,
	input logic trig,
	input logic calib_req,
	input logic reset_req,
	input logic almost_full,
	output tdc_pkg::tdc_state_e tdc_state,
	output logic trig_start,
	output tdc_pkg::stamp_t pulse_count
);

	tdc_pkg::tdc_state_e state_next;
	logic hit_q;
	logic hit_rise;
	logic hit_fall;

	assign hit_rise = hit & ~hit_q;
	assign hit_fall = ~hit & hit_q;

	// restarts the coarse counter
	assign trig_start = (tdc_state == tdc_pkg::IDLE_TRIG);

	always_comb begin
		state_next = tdc_state;
		case (tdc_state)
			tdc_pkg::IDLE: begin
				if (reset_req) begin
					state_next = tdc_pkg::RESET;
				end else if (calib_req) begin
					state_next = tdc_pkg::CALIB;
				end else if (trig) begin
					state_next = tdc_pkg::IDLE_TRIG;
				end else if (hit_rise) begin
					state_next = almost_full ? tdc_pkg::FIFO_FULL : tdc_pkg::RIS_EDGE;
				end
			end
			tdc_pkg::IDLE_TRIG: begin
				state_next = tdc_pkg::TRIGGERED;
			end
			tdc_pkg::TRIGGERED: begin
				if (hit_rise) begin
					state_next = almost_full ? tdc_pkg::FIFO_FULL : tdc_pkg::RIS_EDGE;
				end
			end
			tdc_pkg::RIS_EDGE: begin
				if (hit_fall) begin
					state_next = tdc_pkg::FAL_EDGE;
				end
			end
			tdc_pkg::FAL_EDGE: begin
				state_next = trig ? tdc_pkg::IDLE_TRIG : tdc_pkg::IDLE;
			end
			tdc_pkg::FIFO_FULL: begin
				// no room for edge words so wait out the pulse
				if (hit_fall) begin
					state_next = tdc_pkg::MISSED;
				end
			end
			tdc_pkg::MISSED: begin
				state_next = tdc_pkg::IDLE;
			end
			tdc_pkg::CALIB: begin
				if (hit_rise) begin
					state_next = tdc_pkg::CALIB_HIT;
				end
			end
			tdc_pkg::CALIB_HIT: begin
				state_next = tdc_pkg::IDLE;
			end
			tdc_pkg::RESET: begin
				state_next = tdc_pkg::IDLE;
			end
			default: begin
				state_next = tdc_pkg::IDLE;
			end
		endcase
	end

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			tdc_state <= tdc_pkg::IDLE;
			hit_q <= 1'b0;
		end else begin
			tdc_state <= state_next;
			hit_q <= hit;
		end
	end

	// counts completed pulses and clears on entry to RESET
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			pulse_count <= '0;
		end else if (state_next == tdc_pkg::RESET) begin
			pulse_count <= '0;
		end else if (tdc_state == tdc_pkg::FAL_EDGE) begin
			pulse_count <= pulse_count + 1'b1;
		end
	end

endmodule

// ==== hw/tdc_pkg.sv ====
package tdc_pkg;

	// word header
	localparam logic [3:0] DATA_IDENTIFIER = 4'b0100;

	localparam int COUNTER_BITS = 10;
	localparam int ENCODE_BITS = 7;
	localparam int FINE_BITS = 2;
	localparam int TAPS = 127;
	localparam int STAMP_BITS = 16;

	// output buffer
	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_ALMOST = 14;
	localparam int FIFO_AW = $clog2(FIFO_DEPTH);

	// coarse MSB doubles as the overflow flag
	typedef logic [COUNTER_BITS-1:0] coarse_t;
	typedef logic [FINE_BITS-1:0] fine_t;
	typedef logic [ENCODE_BITS-1:0] tdl_t;
	typedef logic [STAMP_BITS-1:0] stamp_t;
	typedef logic [TAPS-1:0] tap_t;

	typedef enum logic [2:0] {
		TRIGGERED_WORD = 3'd0,
		RISING_WORD = 3'd1,
		FALLING_WORD = 3'd2,
		TIMESTAMP_WORD = 3'd3,
		CALIB_WORD = 3'd4,
		MISS_WORD = 3'd5,
		RESET_WORD = 3'd6
	} word_type_e;

	typedef enum logic [3:0] {
		IDLE = 4'd0,
		IDLE_TRIG = 4'd1,
		TRIGGERED = 4'd2,
		RIS_EDGE = 4'd3,
		FAL_EDGE = 4'd4,
		FIFO_FULL = 4'd5,
		MISSED = 4'd6,
		CALIB = 4'd7,
		CALIB_HIT = 4'd8,
		RESET = 4'd9
	} tdc_state_e;

	// 32-bit data word, header first
	typedef struct packed {
		logic [3:0] id;
		word_type_e wtype;
		stamp_t coarse;
		fine_t fine;
		tdl_t tdl;
	} tdc_word_t;

endpackage

// ==== hw/tdl_encoder.sv ====
`timescale 1ns/1ps

module tdl_encoder (
	input logic CLK,
	input logic arst_n,
	input tdc_pkg::tap_t taps,
	output tdc_pkg::tdl_t tdl_count
);

	localparam int GROUP = 8;
	localparam int NUM_GROUPS = (tdc_pkg::TAPS + GROUP - 1) / GROUP;
	localparam int PADDED = NUM_GROUPS * GROUP;

	logic [PADDED-1:0] taps_pad;
	logic [3:0] group_ones [NUM_GROUPS];
	tdc_pkg::tdl_t ones;

	// pad to a whole number of groups with zeros
	assign taps_pad = {{(PADDED - tdc_pkg::TAPS){1'b0}}, taps};

	// ones count per group of eight taps
	always_comb begin
		for (int g = 0; g < NUM_GROUPS; g++) begin
			group_ones[g] = '0;
			for (int b = 0; b < GROUP; b++) begin
				group_ones[g] = group_ones[g] + 4'(taps_pad[g*GROUP + b]);
			end
		end
	end

	// counting ones instead of finding the edge keeps bubbles harmless
	always_comb begin
		ones = '0;
		for (int g = 0; g < NUM_GROUPS; g++) begin
			ones = ones + tdc_pkg::tdl_t'(group_ones[g]);
		end
	end

	// aligned with the state register update
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			tdl_count <= '0;
		end else begin
			tdl_count <= ones;
		end
	end

endmodule

// ==== hw/word_broker.sv ====
`timescale 1ns/1ps

module word_broker (
	input logic CLK,
	input logic arst_n,
	input tdc_pkg::tdc_state_e tdc_state,
	input tdc_pkg::coarse_t coarse,
	input tdc_pkg::fine_t fine_phase,
	input tdc_pkg::tdl_t tdl_count,
	input tdc_pkg::stamp_t pulse_count,
	input tdc_pkg::stamp_t time_now,
	input logic en_write_timestamp,
	output logic word_valid,
	output tdc_pkg::tdc_word_t word
);

	tdc_pkg::tdc_state_e prev_state;
	tdc_pkg::stamp_t coarse_ext;
	tdc_pkg::stamp_t coarse_sat;
	tdc_pkg::fine_t fine_sat;
	tdc_pkg::stamp_t reset_stamp;
	logic overflow;
	logic valid_next;
	tdc_pkg::tdc_word_t word_next;

	function automatic tdc_pkg::tdc_word_t make_word(
		input tdc_pkg::word_type_e wtype,
		input tdc_pkg::stamp_t stamp,
		input tdc_pkg::fine_t fine,
		input tdc_pkg::tdl_t tdl
	);
		tdc_pkg::tdc_word_t w;
		w.id = tdc_pkg::DATA_IDENTIFIER;
		w.wtype = wtype;
		w.coarse = stamp;
		w.fine = fine;
		w.tdl = tdl;
		return w;
	endfunction

	assign overflow = coarse[tdc_pkg::COUNTER_BITS-1];
	assign coarse_ext = tdc_pkg::stamp_t'(coarse);

	// on overflow the low coarse bits and the fine phase read all ones
	assign coarse_sat = overflow ? tdc_pkg::stamp_t'({tdc_pkg::COUNTER_BITS{1'b1}}) : coarse_ext;
	assign fine_sat = overflow ? '1 : fine_phase;

	always_comb begin
		valid_next = 1'b1;
		word_next = make_word(tdc_pkg::MISS_WORD, '0, '0, '0);
		case ({prev_state, tdc_state})
			{tdc_pkg::IDLE_TRIG, tdc_pkg::TRIGGERED}: begin
				word_next = make_word(tdc_pkg::TRIGGERED_WORD, coarse_ext, fine_phase, tdl_count);
			end
			{tdc_pkg::IDLE, tdc_pkg::RIS_EDGE}: begin
				word_next = make_word(tdc_pkg::RISING_WORD, coarse_ext, fine_phase, tdl_count);
			end
			{tdc_pkg::TRIGGERED, tdc_pkg::RIS_EDGE}: begin
				word_next = make_word(tdc_pkg::RISING_WORD, coarse_sat, fine_sat, tdl_count);
			end
			{tdc_pkg::RIS_EDGE, tdc_pkg::FAL_EDGE}: begin
				word_next = make_word(tdc_pkg::FALLING_WORD, coarse_sat, fine_sat, tdl_count);
			end
			{tdc_pkg::FAL_EDGE, tdc_pkg::IDLE},
			{tdc_pkg::FAL_EDGE, tdc_pkg::IDLE_TRIG}: begin
				valid_next = en_write_timestamp;
				word_next = make_word(tdc_pkg::TIMESTAMP_WORD, pulse_count, '0, '0);
			end
			{tdc_pkg::MISSED, tdc_pkg::IDLE}: begin
				word_next = make_word(tdc_pkg::MISS_WORD, '0, '0, '0);
			end
			{tdc_pkg::RESET, tdc_pkg::IDLE}: begin
				word_next = make_word(tdc_pkg::RESET_WORD, reset_stamp, '0, '0);
			end
			{tdc_pkg::CALIB, tdc_pkg::CALIB_HIT}: begin
				word_next = make_word(tdc_pkg::CALIB_WORD, '0, fine_phase, tdl_count);
			end
			default: begin
				valid_next = 1'b0;
			end
		endcase
	end

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			prev_state <= tdc_pkg::IDLE;
			word_valid <= 1'b0;
		end else begin
			prev_state <= tdc_state;
			word_valid <= valid_next;
		end
	end

	// RESET lasts one cycle, so this holds the entry time
	always_ff @(posedge CLK) begin
		word <= word_next;
		if (tdc_state == tdc_pkg::RESET) begin
			reset_stamp <= time_now;
		end
	end

endmodule

// ==== hw/word_fifo.sv ====
`timescale 1ns/1ps

module word_fifo (
	input logic CLK,
	input logic arst_n,
	input logic word_valid,
	input tdc_pkg::tdc_word_t word,
	input logic out_ready,
	output logic out_valid,
	output tdc_pkg::tdc_word_t out_word,
	output logic almost_full
);

	tdc_pkg::tdc_word_t mem [tdc_pkg::FIFO_DEPTH];
	logic [tdc_pkg::FIFO_AW-1:0] wr_ptr;
	logic [tdc_pkg::FIFO_AW-1:0] rd_ptr;
	logic [tdc_pkg::FIFO_AW:0] count;
	logic [tdc_pkg::FIFO_AW:0] entries;
	logic out_load;
	logic pop;
	logic bypass;
	logic push;

	// output register is free or drains this edge
	assign out_load = !out_valid || out_ready;
	assign pop = out_load && (count != '0);
	// word goes straight to the output register when the buffer is empty
	assign bypass = out_load && (count == '0) && word_valid;
	assign push = word_valid && !bypass;

	assign entries = count + (tdc_pkg::FIFO_AW + 1)'(out_valid);
	assign almost_full = (entries >= tdc_pkg::FIFO_ALMOST);

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			out_valid <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
			if (out_load) begin
				out_valid <= pop || bypass;
			end
		end
	end

	// out_word only changes when the stage is reloaded
	always_ff @(posedge CLK) begin
		if (push) begin
			mem[wr_ptr] <= word;
		end
		if (pop) begin
			out_word <= mem[rd_ptr];
		end else if (bypass) begin
			out_word <= word;
		end
	end

endmodule

// ==== list.f ====
hw/tdc_pkg.sv
hw/coarse_counter.sv
hw/tdl_encoder.sv
hw/tdc_controller.sv
hw/word_broker.sv
hw/word_fifo.sv
hw/tdc_channel_top.sv
tb/tdc_tb.sv

// ==== tb/tdc_tb.sv ====
`timescale 1ns/1ps

module tdc_tb;

	// the saturation wait takes most of the roughly 800 cycles used
	localparam int MAX_CYCLES = 4000;
	localparam int SAT_WAIT = 530;
	localparam int SAT_COUNT = 2 ** (tdc_pkg::COUNTER_BITS - 1);

	logic CLK;
	logic arst_n;
	logic hit;
	logic trig;
	logic calib_req;
	logic reset_req;
	logic en_write_timestamp;
	tdc_pkg::fine_t fine_phase;
	tdc_pkg::tap_t taps;
	logic out_ready;
	logic out_valid;
	tdc_pkg::tdc_word_t out_word;

	integer seed = 32'h0b6d_e8c3;
	int cycles = 0;
	int rst_edge;
	int trig_edge;
	int pulses;
	logic stall;
	logic held = 1'b0;
	tdc_pkg::tdl_t tdl_exp;
	tdc_pkg::tdc_word_t exp_q [$];
	tdc_pkg::tdc_word_t want;
	tdc_pkg::tdc_word_t held_word;

	tdc_channel_top tdc_channel_top_inst (.*);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			stop_run($sformatf("Timeout: run not finished after %0d cycles", MAX_CYCLES));
		end
	end

	// accepted words in order against the reference queue
	always @(posedge CLK) begin
		if (arst_n) begin
			if (held) begin
				assert (out_valid && out_word == held_word)
				else stop_run($sformatf("Error at %0t: output word changed while stalled",
					$time));
			end
			if (out_valid && out_ready) begin
				assert (exp_q.size() != 0)
				else stop_run("An output word arrived when none was expected");
				want = exp_q.pop_front();
				assert (out_word == want)
				else stop_run($sformatf("Error at %0t: got word %h, expected %h",
					$time, out_word, want));
			end
			held = out_valid && !out_ready;
			held_word = out_word;
		end
	end

	task automatic next_cycle();
		int r;
		@(posedge CLK);
		#2;
		r = $random(seed);
		if (!stall) begin
			out_ready = r[0];
		end
	endtask

	// k ones with one bubble swapped above the edge
	task automatic new_sample();
		int k;
		int r;
		k = 2 + ($unsigned($random(seed)) % 124);
		r = $random(seed);
		taps = '0;
		for (int i = 0; i < k; i++) begin
			taps[i] = 1'b1;
		end
		taps[k-2] = 1'b0;
		taps[k] = 1'b1;
		fine_phase = r[1:0];
		tdl_exp = k[6:0];
	endtask

	task automatic expect_word(input tdc_pkg::word_type_e wtype, input int stamp,
			input tdc_pkg::fine_t fine, input tdc_pkg::tdl_t tdl);
		tdc_pkg::tdc_word_t w;
		w.id = tdc_pkg::DATA_IDENTIFIER;
		w.wtype = wtype;
		w.coarse = stamp[15:0];
		w.fine = fine;
		w.tdl = tdl;
		exp_q.push_back(w);
	endtask

	// coarse from the edges since the trigger was sampled
	task automatic expect_edge(input tdc_pkg::word_type_e wtype, input logic sat);
		int count;
		count = cycles - trig_edge;
		if (count >= SAT_COUNT && sat) begin
			expect_word(wtype, 2 * SAT_COUNT - 1, 2'b11, tdl_exp);
		end else begin
			expect_word(wtype, (count >= SAT_COUNT) ? SAT_COUNT : count, fine_phase, tdl_exp);
		end
	endtask

	task automatic run_pulse(input logic with_trig, input int delay, input int width);
		logic missed;
		if (with_trig) begin
			new_sample();
			trig = 1'b1;
			trig_edge = cycles + 1;
			next_cycle();
			trig = 1'b0;
			expect_word(tdc_pkg::TRIGGERED_WORD, 0, fine_phase, tdl_exp);
			repeat (delay) next_cycle();
		end
		new_sample();
		hit = 1'b1;
		missed = (exp_q.size() >= tdc_pkg::FIFO_ALMOST);
		if (!missed) begin
			expect_edge(tdc_pkg::RISING_WORD, with_trig);
		end
		repeat (width) next_cycle();
		new_sample();
		hit = 1'b0;
		if (missed) begin
			expect_word(tdc_pkg::MISS_WORD, 0, 2'b00, '0);
		end else begin
			pulses++;
			expect_edge(tdc_pkg::FALLING_WORD, 1'b1);
			if (en_write_timestamp) begin
				expect_word(tdc_pkg::TIMESTAMP_WORD, pulses, 2'b00, '0);
			end
		end
		repeat (5) next_cycle();
	endtask

	task automatic run_calib();
		calib_req = 1'b1;
		next_cycle();
		calib_req = 1'b0;
		next_cycle();
		new_sample();
		hit = 1'b1;
		expect_word(tdc_pkg::CALIB_WORD, 0, fine_phase, tdl_exp);
		repeat (3) next_cycle();
		hit = 1'b0;
		repeat (5) next_cycle();
	endtask

	task automatic request_reset();
		reset_req = 1'b1;
		// time counter value in the RESET cycle
		expect_word(tdc_pkg::RESET_WORD, cycles + 1 - rst_edge, 2'b00, '0);
		pulses = 0;
		next_cycle();
		reset_req = 1'b0;
		repeat (5) next_cycle();
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0) begin
			next_cycle();
		end
	endtask

	initial begin
		arst_n = 1'b0;
		hit = 1'b0;
		trig = 1'b0;
		calib_req = 1'b0;
		reset_req = 1'b0;
		en_write_timestamp = 1'b0;
		fine_phase = '0;
		taps = '0;
		out_ready = 1'b0;
		stall = 1'b0;
		pulses = 0;
		repeat (3) next_cycle();
		arst_n = 1'b1;
		rst_edge = cycles;

		repeat (4) begin
			run_pulse(1'b1, 3, 2 + ($unsigned($random(seed)) % 5));
		end
		run_pulse(1'b0, 0, 3);

		en_write_timestamp = 1'b1;
		repeat (3) begin
			run_pulse(1'b0, 0, 2);
		end
		run_pulse(1'b1, 3, 2);

		// hit after the coarse counter has saturated
		run_pulse(1'b1, SAT_WAIT, 3);
		run_pulse(1'b0, 0, 2);

		run_calib();
		request_reset();
		run_pulse(1'b0, 0, 3);

		// back-pressure until the miss path is taken
		wait_drain();
		stall = 1'b1;
		out_ready = 1'b0;
		en_write_timestamp = 1'b0;
		repeat (9) begin
			run_pulse(1'b0, 0, 2);
		end
		stall = 1'b0;
		wait_drain();
		repeat (10) next_cycle();

		if (exp_q.size() == 0 && !out_valid) begin
			$display("TEST PASSED");
			$finish;
		end else begin
			stop_run("An unexpected word was left at the output at the end of the run");
		end
	end

endmodule
